// File: logic/enet_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "enet_params.svh"

interface enet_cfg_if;

    logic [`ENET_DATA_W-1:0] wdata;
    logic                    txic_wen;
    logic                    rxic_wen;
    logic                    mmfr_wen;
    logic                    mscr_wen;
    // EIR write-one-to-clear of the coalescer flags
    logic                    tx_clr;
    logic                    rx_clr;

    modport ctrl (
        output wdata, txic_wen, rxic_wen, mmfr_wen, mscr_wen, tx_clr, rx_clr
    );

    modport coal_tx (input wdata, txic_wen, tx_clr);

    modport coal_rx (input wdata, rxic_wen, rx_clr);

    modport mdio (input wdata, mmfr_wen, mscr_wen);

endinterface

`default_nettype wire

// File: logic/enet_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "enet_params.svh"

module enet_core (
    input  wire                        clk,
    input  wire                        arst_n,

    input  wire                        reg_valid,
    output wire                        reg_ready,
    input  wire                        reg_write,
    input  wire  [`ENET_ADDR_W-1:0]    reg_addr,
    input  wire  [`ENET_DATA_W-1:0]    reg_wdata,

    output wire                        rsp_valid,
    input  wire                        rsp_ready,
    output wire  [`ENET_DATA_W-1:0]    rsp_rdata,

    input  wire                        tx_frame_done,
    input  wire                        rx_frame_done,

    output wire                        irq,

    output wire                        mdc,
    output wire                        mdo,
    output wire                        mdo_en,
    input  wire                        mdi
);

    import enet_pkg::*;

    wire [`ENET_DATA_W-1:0] txic;
    wire [`ENET_DATA_W-1:0] rxic;
    wire                    txf;
    wire                    rxf;
    mmfr_t                  mmfr;
    wire [`ENET_DATA_W-1:0] mscr;
    wire                    mii_done;

    enet_cfg_if cfg_if ();

    enet_reg_ctrl u_reg_ctrl (
        .clk        (clk            ),
        .arst_n     (arst_n         ),
        .reg_valid  (reg_valid      ),
        .reg_ready  (reg_ready      ),
        .reg_write  (reg_write      ),
        .reg_addr   (reg_addr       ),
        .reg_wdata  (reg_wdata      ),
        .rsp_valid  (rsp_valid      ),
        .rsp_ready  (rsp_ready      ),
        .rsp_rdata  (rsp_rdata      ),
        .irq        (irq            ),
        .cfg        (cfg_if.ctrl    ),
        .txic       (txic           ),
        .rxic       (rxic           ),
        .txf        (txf            ),
        .rxf        (rxf            ),
        .mmfr       (mmfr           ),
        .mscr       (mscr           ),
        .mii_done   (mii_done       )
    );

    enet_intr_coalesce #(
        .IS_RX      (1'b0           ))
    u_tx_coal (
        .clk        (clk            ),
        .arst_n     (arst_n         ),
        .cfg        (cfg_if.coal_tx ),
        .frame_event(tx_frame_done  ),
        .ic_reg     (txic           ),
        .intr_flag  (txf            )
    );

    enet_intr_coalesce #(
        .IS_RX      (1'b1           ))
    u_rx_coal (
        .clk        (clk            ),
        .arst_n     (arst_n         ),
        .cfg        (cfg_if.coal_rx ),
        .frame_event(rx_frame_done  ),
        .ic_reg     (rxic           ),
        .intr_flag  (rxf            )
    );

    enet_mdio_master u_mdio_master (
        .clk        (clk            ),
        .arst_n     (arst_n         ),
        .cfg        (cfg_if.mdio    ),
        .mmfr       (mmfr           ),
        .mscr       (mscr           ),
        .mii_done   (mii_done       ),
        .mdc        (mdc            ),
        .mdo        (mdo            ),
        .mdo_en     (mdo_en         ),
        .mdi        (mdi            )
    );

endmodule

`default_nettype wire

// File: logic/enet_intr_coalesce.sv
`timescale 1ns/1ps
`default_nettype none

`include "enet_params.svh"

module enet_intr_coalesce #(
    // picks the rx strobes of the config interface
    parameter bit IS_RX = 1'b0
) (
    input  wire                        clk,
    input  wire                        arst_n,
    enet_cfg_if                        cfg,
    input  wire                        frame_event,
    output logic [`ENET_DATA_W-1:0]    ic_reg,
    output logic                       intr_flag
);

    localparam int FT_W = `ENET_IC_FT_W;
    localparam int TT_W = `ENET_IC_TT_W;

    logic            ic_wen;
    logic            clr;
    logic            ic_en;
    logic [FT_W-1:0] ft;
    logic [FT_W-1:0] ft_eff;
    logic [TT_W-1:0] tt;
    logic [FT_W-1:0] cnt;
    logic [FT_W:0]   cnt_inc;
    logic [TT_W-1:0] timer;
    logic            hit_frames;
    logic            hit_timer;
    logic            fire;

    if (IS_RX) begin : g_rx
        assign ic_wen = cfg.rxic_wen;
        assign clr    = cfg.rx_clr;
    end else begin : g_tx
        assign ic_wen = cfg.txic_wen;
        assign clr    = cfg.tx_clr;
    end

    assign ic_en  = ic_reg[`ENET_IC_EN];
    assign ft     = ic_reg[`ENET_IC_FT_LSB +: FT_W];
    assign tt     = ic_reg[TT_W-1:0];
    // threshold 0 behaves like 1
    assign ft_eff = (ft == '0) ? FT_W'(1) : ft;

    assign cnt_inc    = {1'b0, cnt} + 1'b1;
    assign hit_frames = frame_event && (cnt_inc >= {1'b0, ft_eff});
    // timer runs from the first event still waiting
    assign hit_timer  = (tt != '0) && (cnt != '0) && (timer == tt - TT_W'(1));
    assign fire       = ic_en ? (hit_frames || hit_timer) : frame_event;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ic_reg <= '0;
            cnt    <= '0;
            timer  <= '0;
        end else if (ic_wen) begin
            ic_reg <= cfg.wdata;
            cnt    <= '0;
            timer  <= '0;
        end else if (fire) begin
            cnt    <= '0;
            timer  <= '0;
        end else begin
            if (ic_en && frame_event) begin
                cnt <= cnt_inc[FT_W-1:0];
            end
            if (cnt != '0) begin
                timer <= timer + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            intr_flag <= 1'b0;
        end else if (fire) begin
            intr_flag <= 1'b1;
        end else if (clr) begin
            intr_flag <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/enet_mdio_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "enet_params.svh"

module enet_mdio_master (
    input  wire                        clk,
    input  wire                        arst_n,
    enet_cfg_if.mdio                   cfg,
    output enet_pkg::mmfr_t            mmfr,
    output logic [`ENET_DATA_W-1:0]    mscr,
    output logic                       mii_done,
    output logic                       mdc,
    output logic                       mdo,
    output logic                       mdo_en,
    input  wire                        mdi
);

    localparam int SPD_W = `ENET_MSCR_SPEED_W;

    // bit index of the 64 bit sequence, preamble then frame
    localparam logic [6:0] FIRST_FRAME_BIT = 7'd32;
    localparam logic [6:0] LAST_BIT        = 7'd63;
    localparam logic [4:0] TA_POS          = 5'd14;

    logic [SPD_W-1:0] speed;
    logic             dis_pre;
    logic             busy;
    logic [SPD_W-1:0] div_cnt;
    logic             half_tick;
    logic [6:0]       idx;
    logic             in_frame;
    logic             is_read;
    logic             start;
    logic             cur_bit;

    assign speed   = mscr[`ENET_MSCR_SPEED_LSB +: SPD_W];
    assign dis_pre = mscr[`ENET_MSCR_DIS_PRE];
    assign is_read = (mmfr.f.op == `ENET_MDIO_OP_READ);
    assign start   = cfg.mmfr_wen && !busy && (speed != '0);

    // half an mdc period is speed+1 clk cycles
    assign half_tick = busy && (div_cnt >= speed);

    assign in_frame = idx[5];
    assign cur_bit  = in_frame ? mmfr.raw[~idx[4:0]] : 1'b1;

    assign mdo    = busy & cur_bit;
    // release the line for turnaround and data on reads
    assign mdo_en = busy && !(is_read && in_frame && (idx[4:0] >= TA_POS));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mscr <= '0;
        end else if (cfg.mscr_wen) begin
            mscr <= cfg.wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            div_cnt  <= '0;
            mdc      <= 1'b0;
            idx      <= '0;
            mii_done <= 1'b0;
        end else begin
            mii_done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                div_cnt <= '0;
                mdc     <= 1'b0;
                idx     <= dis_pre ? FIRST_FRAME_BIT : '0;
            end else if (busy) begin
                div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                if (half_tick) begin
                    mdc <= ~mdc;
                    // falling edge moves on to the next bit
                    if (mdc) begin
                        if (idx == LAST_BIT) begin
                            busy     <= 1'b0;
                            mii_done <= 1'b1;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mmfr.raw <= '0;
        end else if (cfg.mmfr_wen && !busy) begin
            mmfr.raw <= cfg.wdata;
        end else if (half_tick && !mdc && is_read && in_frame && idx[4]) begin
            // rising mdc in the data phase, shift in msb first
            mmfr.f.data <= {mmfr.f.data[14:0], mdi};
        end
    end

endmodule

`default_nettype wire

// File: logic/enet_params.svh
`ifndef ENET_PARAMS_SVH
`define ENET_PARAMS_SVH

`define ENET_ADDR_W             12
`define ENET_DATA_W             32

// register offsets
`define ENET_EIR_OFS            12'h004
`define ENET_EIMR_OFS           12'h008
`define ENET_MMFR_OFS           12'h040
`define ENET_MSCR_OFS           12'h044
`define ENET_TXIC_OFS           12'h0F0
`define ENET_RXIC_OFS           12'h100

// event bits in EIR
`define ENET_EIR_TXF            27
`define ENET_EIR_RXF            25
`define ENET_EIR_MII            23

// TXIC / RXIC fields
`define ENET_IC_EN              31
`define ENET_IC_FT_LSB          20
`define ENET_IC_FT_W            8
`define ENET_IC_TT_W            16

// MSCR fields
`define ENET_MSCR_SPEED_LSB     1
`define ENET_MSCR_SPEED_W       6
`define ENET_MSCR_DIS_PRE       7

`define ENET_MDIO_OP_READ       2'b10

`endif

// File: logic/enet_pkg.sv
`default_nettype none

`include "enet_params.svh"

package enet_pkg;

    // management frame as it goes out on the wire, msb first
    typedef struct packed {
        logic [1:0]  st;
        logic [1:0]  op;
        logic [4:0]  pa;
        logic [4:0]  ra;
        logic [1:0]  ta;
        logic [15:0] data;
    } mmfr_fields_t;

    // raw view for the register bus, field view for the MDIO engine
    typedef union packed {
        logic [`ENET_DATA_W-1:0] raw;
        mmfr_fields_t            f;
    } mmfr_t;

endpackage

`default_nettype wire

// File: logic/enet_reg_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "enet_params.svh"

module enet_reg_ctrl (
    input  wire                        clk,
    input  wire                        arst_n,

    input  wire                        reg_valid,
    output logic                       reg_ready,
    input  wire                        reg_write,
    input  wire  [`ENET_ADDR_W-1:0]    reg_addr,
    input  wire  [`ENET_DATA_W-1:0]    reg_wdata,

    output logic                       rsp_valid,
    input  wire                        rsp_ready,
    output logic [`ENET_DATA_W-1:0]    rsp_rdata,

    output logic                       irq,

    enet_cfg_if.ctrl                   cfg,

    input  wire  [`ENET_DATA_W-1:0]    txic,
    input  wire  [`ENET_DATA_W-1:0]    rxic,
    input  wire                        txf,
    input  wire                        rxf,
    input  wire  enet_pkg::mmfr_t      mmfr,
    input  wire  [`ENET_DATA_W-1:0]    mscr,
    input  wire                        mii_done
);

    logic                    accept;
    logic                    wr_en;
    logic                    eir_wen;
    logic                    eimr_wen;
    logic                    mii_ev;
    logic [`ENET_DATA_W-1:0] eimr;
    logic [`ENET_DATA_W-1:0] eir;
    logic [`ENET_DATA_W-1:0] rd_data;

    // one request in flight, ready drops while the response waits
    assign reg_ready = ~rsp_valid;
    assign accept    = reg_valid & reg_ready;
    assign wr_en     = accept & reg_write;

    assign eir_wen  = wr_en && (reg_addr == `ENET_EIR_OFS);
    assign eimr_wen = wr_en && (reg_addr == `ENET_EIMR_OFS);

    assign cfg.wdata    = reg_wdata;
    assign cfg.txic_wen = wr_en && (reg_addr == `ENET_TXIC_OFS);
    assign cfg.rxic_wen = wr_en && (reg_addr == `ENET_RXIC_OFS);
    assign cfg.mmfr_wen = wr_en && (reg_addr == `ENET_MMFR_OFS);
    assign cfg.mscr_wen = wr_en && (reg_addr == `ENET_MSCR_OFS);
    assign cfg.tx_clr   = eir_wen && reg_wdata[`ENET_EIR_TXF];
    assign cfg.rx_clr   = eir_wen && reg_wdata[`ENET_EIR_RXF];

    always_comb begin
        eir                = '0;
        eir[`ENET_EIR_TXF] = txf;
        eir[`ENET_EIR_RXF] = rxf;
        eir[`ENET_EIR_MII] = mii_ev;
    end

    always_comb begin
        case (reg_addr)
            `ENET_EIR_OFS:  rd_data = eir;
            `ENET_EIMR_OFS: rd_data = eimr;
            `ENET_MMFR_OFS: rd_data = mmfr.raw;
            `ENET_MSCR_OFS: rd_data = mscr;
            `ENET_TXIC_OFS: rd_data = txic;
            `ENET_RXIC_OFS: rd_data = rxic;
            default:        rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // writes answer with zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_rdata <= '0;
        end else if (accept) begin
            rsp_rdata <= reg_write ? '0 : rd_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            eimr <= '0;
        end else if (eimr_wen) begin
            eimr <= reg_wdata;
        end
    end

    // a new MII event wins over a clear in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mii_ev <= 1'b0;
        end else if (mii_done) begin
            mii_ev <= 1'b1;
        end else if (eir_wen && reg_wdata[`ENET_EIR_MII]) begin
            mii_ev <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= |(eir & eimr);
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f src.f --top-module enet_core_tb &&
./obj_dir/Venet_core_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: src.f
+incdir+logic
logic/enet_pkg.sv
logic/enet_cfg_if.sv
logic/enet_intr_coalesce.sv
logic/enet_mdio_master.sv
logic/enet_reg_ctrl.sv
logic/enet_core.sv
verification/mdio_phy_model.sv
verification/enet_core_tb.sv

// File: verification/enet_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "enet_params.svh"

module enet_core_tb;

    // longest test is an MDIO frame of about 400 cycles
    localparam int TIMEOUT_CYCLES = 20000;

    logic clk, arst_n, reg_valid, reg_ready, reg_write, rsp_valid, rsp_ready;
    logic [`ENET_ADDR_W-1:0] reg_addr;
    logic [`ENET_DATA_W-1:0] reg_wdata, rsp_rdata;
    logic tx_frame_done, rx_frame_done, irq, mdc, mdo, mdo_en, mdi;
    logic [31:0] last_frame, last_pre;
    logic ta_driven;
    int frame_cnt;

    integer seed = 60;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    string q_name[$];
    logic [31:0] q_got[$];
    logic [31:0] q_exp[$];

    enet_core DUT (.*);

    mdio_phy_model u_phy (.mdc(mdc), .mdo(mdo), .mdo_en(mdo_en), .mdi(mdi),
        .last_frame(last_frame), .last_pre(last_pre), .ta_driven(ta_driven),
        .frame_cnt(frame_cnt));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] eir_value(input bit txf, input bit rxf, input bit mii);
        logic [31:0] w;
        w = '0;
        w[`ENET_EIR_TXF] = txf;
        w[`ENET_EIR_RXF] = rxf;
        w[`ENET_EIR_MII] = mii;
        return w;
    endfunction

    function automatic logic irq_level(input logic [31:0] eir, input logic [31:0] eimr);
        return |(eir & eimr);
    endfunction

    // flag after a number of events and cycles since the first pending one
    function automatic logic coal_flag(input logic [31:0] ic, input int events, input int cyc);
        int ft;
        int tt;
        ft = ic[27:20];
        tt = ic[15:0];
        if (!ic[`ENET_IC_EN]) return events > 0;
        if (ft == 0) ft = 1;
        return (events >= ft) || (tt != 0 && events > 0 && cyc >= tt);
    endfunction

    function automatic logic [31:0] mmfr_after_read(input logic [31:0] w);
        return {w[31:16], w[27:23], w[22:18], 6'b101010};
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        q_name.push_back(name);
        q_got.push_back(got);
        q_exp.push_back(exp);
    endtask

    always @(negedge clk) begin
        while (q_name.size() > 0) begin
            checks++;
            assert (q_got[0] === q_exp[0]) else begin
                errors++;
                $display("Mismatch at %0t: %s got %h expected %h", $time, q_name[0],
                    q_got[0], q_exp[0]);
            end
            void'(q_name.pop_front());
            void'(q_got.pop_front());
            void'(q_exp.pop_front());
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic bus(input bit wr, input logic [11:0] addr, input logic [31:0] wd,
                       output logic [31:0] rd);
        reg_valid = 1'b1;
        reg_write = wr;
        reg_addr  = addr;
        reg_wdata = wd;
        @(negedge clk);
        while (!reg_ready) @(negedge clk);
        @(posedge clk);
        #1 reg_valid = 1'b0;
        while (!rsp_valid) @(negedge clk);
        rd = rsp_rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] wd);
        logic [31:0] unused;
        bus(1'b1, addr, wd, unused);
    endtask

    task automatic read_check(input string name, input logic [11:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        bus(1'b0, addr, '0, rd);
        expect_eq(name, rd, exp);
    endtask

    task automatic pulse(input bit rx);
        if (rx) rx_frame_done = 1'b1;
        else tx_frame_done = 1'b1;
        @(posedge clk);
        #1;
        tx_frame_done = 1'b0;
        rx_frame_done = 1'b0;
    endtask

    task automatic poll_mii_event();
        logic [31:0] rd;
        int tries;
        tries = 0;
        rd = '0;
        while (!rd[`ENET_EIR_MII] && tries < 300) begin
            bus(1'b0, `ENET_EIR_OFS, '0, rd);
            tries++;
        end
        assert (rd[`ENET_EIR_MII]) else begin
            errors++;
            $display("MDIO frame never raised the MII event");
        end
    endtask

    initial begin
        logic [31:0] first;
        logic [31:0] w;
        int fc;
        arst_n        = 1'b0;
        reg_valid     = 1'b0;
        reg_write     = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        rsp_ready     = 1'b1;
        tx_frame_done = 1'b0;
        rx_frame_done = 1'b0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        wait_cycles(1);

        // reset values and read back
        expect_eq("irq", irq, 0);
        expect_eq("rsp_valid", rsp_valid, 0);
        expect_eq("reg_ready", reg_ready, 1);
        expect_eq("mdo_en", mdo_en, 0);
        read_check("EIR", `ENET_EIR_OFS, 0);
        read_check("EIMR", `ENET_EIMR_OFS, 0);
        read_check("MMFR", `ENET_MMFR_OFS, 0);
        read_check("MSCR", `ENET_MSCR_OFS, 0);
        read_check("TXIC", `ENET_TXIC_OFS, 0);
        read_check("RXIC", `ENET_RXIC_OFS, 0);
        w = $random(seed);
        write_reg(`ENET_EIMR_OFS, w);
        read_check("EIMR", `ENET_EIMR_OFS, w);
        w = $random(seed);
        write_reg(`ENET_MSCR_OFS, w);
        read_check("MSCR", `ENET_MSCR_OFS, w);
        w = $random(seed);
        write_reg(`ENET_TXIC_OFS, w);
        read_check("TXIC", `ENET_TXIC_OFS, w);
        w = $random(seed);
        write_reg(`ENET_RXIC_OFS, w);
        read_check("RXIC", `ENET_RXIC_OFS, w);
        read_check("unmapped", 12'h00C, 0);

        // response held while rsp_ready is low
        w = $random(seed) | 32'h1;
        write_reg(`ENET_EIMR_OFS, w);
        rsp_ready = 1'b0;
        reg_valid = 1'b1;
        reg_write = 1'b0;
        reg_addr  = `ENET_EIMR_OFS;
        @(negedge clk);
        while (!reg_ready) @(negedge clk);
        @(posedge clk);
        #1 reg_valid = 1'b0;
        first = rsp_rdata;
        expect_eq("rsp_rdata", first, w);
        repeat (4) begin
            @(negedge clk);
            expect_eq("rsp_valid", rsp_valid, 1);
            expect_eq("rsp_rdata", rsp_rdata, first);
            expect_eq("reg_ready", reg_ready, 0);
        end
        @(posedge clk);
        #1 rsp_ready = 1'b1;
        wait_cycles(1);
        expect_eq("rsp_valid", rsp_valid, 0);
        write_reg(`ENET_EIMR_OFS, 0);
        write_reg(`ENET_MSCR_OFS, 0);
        write_reg(`ENET_TXIC_OFS, 0);
        write_reg(`ENET_RXIC_OFS, 0);

        // coalescing off
        pulse(0);
        wait_cycles(2);
        read_check("EIR", `ENET_EIR_OFS, eir_value(1, 0, 0));
        expect_eq("irq", irq, irq_level(eir_value(1, 0, 0), 0));
        write_reg(`ENET_EIMR_OFS, 32'h1 << `ENET_EIR_TXF);
        wait_cycles(2);
        expect_eq("irq", irq, irq_level(eir_value(1, 0, 0), 32'h1 << `ENET_EIR_TXF));
        write_reg(`ENET_EIR_OFS, 0);
        read_check("EIR", `ENET_EIR_OFS, eir_value(1, 0, 0));
        write_reg(`ENET_EIR_OFS, 32'h1 << `ENET_EIR_TXF);
        read_check("EIR", `ENET_EIR_OFS, eir_value(0, 0, 0));
        wait_cycles(2);
        expect_eq("irq", irq, 0);
        write_reg(`ENET_EIMR_OFS, 0);

        // frame threshold of three
        w = (32'h1 << 31) | (32'd3 << 20);
        write_reg(`ENET_RXIC_OFS, w);
        pulse(1);
        pulse(1);
        wait_cycles(2);
        read_check("EIR", `ENET_EIR_OFS, eir_value(0, coal_flag(w, 2, 2), 0));
        pulse(1);
        wait_cycles(2);
        read_check("EIR", `ENET_EIR_OFS, eir_value(0, coal_flag(w, 3, 2), 0));
        write_reg(`ENET_EIR_OFS, 32'h1 << `ENET_EIR_RXF);
        write_reg(`ENET_RXIC_OFS, 0);

        // timer threshold
        w = (32'h1 << 31) | (32'd200 << 20) | 32'd50;
        write_reg(`ENET_TXIC_OFS, w);
        pulse(0);
        wait_cycles(39);
        read_check("EIR", `ENET_EIR_OFS, eir_value(coal_flag(w, 1, 40), 0, 0));
        wait_cycles(17);
        read_check("EIR", `ENET_EIR_OFS, eir_value(coal_flag(w, 1, 60), 0, 0));
        write_reg(`ENET_EIR_OFS, 32'h1 << `ENET_EIR_TXF);
        write_reg(`ENET_TXIC_OFS, 0);

        // MDIO write frame
        write_reg(`ENET_MSCR_OFS, 32'd2 << `ENET_MSCR_SPEED_LSB);
        w = {2'b01, 2'b01, 28'($random(seed))};
        fc = frame_cnt;
        write_reg(`ENET_MMFR_OFS, w);
        poll_mii_event();
        expect_eq("phy frame_cnt", frame_cnt, fc + 1);
        expect_eq("phy preamble", last_pre, 32'hFFFF_FFFF);
        expect_eq("phy frame", last_frame, w);
        read_check("MMFR", `ENET_MMFR_OFS, w);
        write_reg(`ENET_EIR_OFS, 32'h1 << `ENET_EIR_MII);
        read_check("EIR", `ENET_EIR_OFS, eir_value(0, 0, 0));

        // MDIO read frame
        w = {2'b01, `ENET_MDIO_OP_READ, 5'($random(seed)), 5'($random(seed)), 18'h0};
        write_reg(`ENET_MMFR_OFS, w);
        poll_mii_event();
        expect_eq("phy ta mdo_en", ta_driven, 0);
        read_check("MMFR", `ENET_MMFR_OFS, mmfr_after_read(w));
        write_reg(`ENET_EIR_OFS, 32'h1 << `ENET_EIR_MII);

        @(negedge clk);
        @(negedge clk);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/mdio_phy_model.sv
`timescale 1ns/1ps
`default_nettype none

module mdio_phy_model (
    input  wire         mdc,
    input  wire         mdo,
    input  wire         mdo_en,
    output logic        mdi,
    output logic [31:0] last_frame,
    output logic [31:0] last_pre,
    output logic        ta_driven,
    output int          frame_cnt
);

    logic [63:0] sh;
    logic [63:0] nsh;
    logic [15:0] reply;
    logic        rd;
    int          cnt;

    initial begin
        mdi        = 1'b0;
        last_frame = '0;
        last_pre   = '0;
        ta_driven  = 1'b0;
        frame_cnt  = 0;
        sh         = '0;
        reply      = '0;
        rd         = 1'b0;
        cnt        = 0;
    end

    // 32 preamble bits, then st op pa ra ta data
    always @(posedge mdc) begin
        nsh = {sh[62:0], mdo};
        if (cnt == 0) begin
            ta_driven = 1'b0;
        end
        if (cnt == 46 || cnt == 47) begin
            ta_driven = ta_driven | mdo_en;
        end
        if (cnt + 1 == 46) begin
            rd    = (nsh[11:10] == 2'b10);
            reply = {nsh[9:5], nsh[4:0], 6'b101010};
        end
        if (cnt + 1 == 64) begin
            last_frame = nsh[31:0];
            last_pre   = nsh[63:32];
            frame_cnt  = frame_cnt + 1;
            cnt        = 0;
            rd         = 1'b0;
        end else begin
            cnt = cnt + 1;
        end
        sh = nsh;
    end

    // next data bit goes out after the falling edge
    always @(negedge mdc) begin
        if (rd && cnt >= 48 && cnt < 64) begin
            mdi = reply[63-cnt];
        end else begin
            mdi = 1'b0;
        end
    end

endmodule

`default_nettype wire
